//--- tracker_params.svh
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

////////////////////
// frame geometry
////////////////////

// active camera area in pixels
`define FRAME_WIDTH 320
`define FRAME_HEIGHT 240

////////////////////
// colour thresholds
////////////////////

// player 1 red led: strong red, almost no green or blue
`define P1_RED_MIN 13
`define P1_OTHER_MAX 3
// player 2 white led: every channel close to full scale
`define P2_MIN 12

////////////////////
// motion and divider
////////////////////

// frames summed into one displacement report
`define FRAMES_PER_WINDOW 16
// one quotient bit per step, same as the dividend width
`define DIV_STEPS 24

`endif

//--- pixel_pkg.sv
package pixel_pkg;

    ////////////////////
    // pixel stream
    ////////////////////

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb444_t;

    // column, wide enough for 320
    typedef logic [8:0] x_coord_t;
    // row, wide enough for 240
    typedef logic [7:0] y_coord_t;

    ////////////////////
    // per-frame totals
    ////////////////////

    // sum of coordinates over one frame
    typedef logic [23:0] coord_sum_t;
    // matching pixels in one frame
    typedef logic [15:0] pixel_count_t;

    // result of the colour test on one pixel
    typedef enum logic [1:0] {
        none = 2'd0,
        p1   = 2'd1,
        p2   = 2'd2
    } player_class_t;

endpackage

//--- motion_pkg.sv
package motion_pkg;

    ////////////////////
    // motion results
    ////////////////////

    // accumulated motion over one window, two's complement
    // positive x is rightwards, positive y is downwards
    typedef logic signed [8:0] delta_t;

    // unsigned size of a displacement, one display byte
    typedef logic [7:0] magnitude_t;

    ////////////////////
    // display word
    ////////////////////

    // eight hex digits, four bytes
    // p2_dx in the top byte, then p2_dy, p1_dx, p1_dy
    typedef logic [31:0] hex_word_t;

    // byte lanes inside hex_word_t
    typedef enum logic [1:0] {
        lane_p1_dy = 2'd0,
        lane_p1_dx = 2'd1,
        lane_p2_dy = 2'd2,
        lane_p2_dx = 2'd3
    } display_lane_t;

endpackage

//--- pixel_classifier.sv
`include "tracker_params.svh"

module pixel_classifier (
    input  logic                      clk_65mhz,
    input  logic                      reset,
    input  pixel_pkg::rgb444_t        pixel,
    input  pixel_pkg::x_coord_t       pixel_x,
    input  pixel_pkg::y_coord_t       pixel_y,
    input  logic                      pixel_valid,
    output logic                      class_valid,
    output pixel_pkg::player_class_t  pixel_class,
    output pixel_pkg::x_coord_t       class_x,
    output pixel_pkg::y_coord_t       class_y
);
    import pixel_pkg::*;

    logic [3:0]    red;
    logic [3:0]    green;
    logic [3:0]    blue;
    logic          in_area;
    player_class_t next_class;

    // channel split of the 4:4:4 pixel
    assign red   = pixel[11:8];
    assign green = pixel[7:4];
    assign blue  = pixel[3:0];

    always_comb begin
        // coordinates past the edge are blanking, never counted
        in_area = (pixel_x < `FRAME_WIDTH) && (pixel_y < `FRAME_HEIGHT);
        // red test wins, a bright white never passes it anyway
        if (red > `P1_RED_MIN && green < `P1_OTHER_MAX && blue < `P1_OTHER_MAX) begin
            next_class = p1;
        end else if (red > `P2_MIN && green > `P2_MIN && blue > `P2_MIN) begin
            next_class = p2;
        end else begin
            next_class = none;
        end
    end

    // valid strobe is control
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            class_valid <= 1'b0;
        end else begin
            class_valid <= pixel_valid && in_area;
        end
    end

    // class travels with its own coordinates
    always_ff @(posedge clk_65mhz) begin
        pixel_class <= next_class;
        class_x     <= pixel_x;
        class_y     <= pixel_y;
    end

endmodule

//--- centroid_accumulator.sv
module centroid_accumulator (
    input  logic                      clk_65mhz,
    input  logic                      reset,
    input  logic                      class_valid,
    input  pixel_pkg::player_class_t  pixel_class,
    input  pixel_pkg::x_coord_t       class_x,
    input  pixel_pkg::y_coord_t       class_y,
    input  logic                      frame_done,
    output logic                      sums_valid,
    output pixel_pkg::coord_sum_t     p1_x_sum,
    output pixel_pkg::coord_sum_t     p1_y_sum,
    output pixel_pkg::coord_sum_t     p2_x_sum,
    output pixel_pkg::coord_sum_t     p2_y_sum,
    output pixel_pkg::pixel_count_t   p1_count,
    output pixel_pkg::pixel_count_t   p2_count,
    output logic                      p1_present,
    output logic                      p2_present
);
    import pixel_pkg::*;

    // running totals, index 0 is player 1, index 1 is player 2
    coord_sum_t   x_run   [2];
    coord_sum_t   y_run   [2];
    pixel_count_t cnt_run [2];
    logic [1:0]   hit;

    // which player this pixel feeds
    assign hit[0] = class_valid && (pixel_class == p1);
    assign hit[1] = class_valid && (pixel_class == p2);

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            sums_valid <= 1'b0;
            p1_x_sum   <= '0;
            p1_y_sum   <= '0;
            p2_x_sum   <= '0;
            p2_y_sum   <= '0;
            p1_count   <= '0;
            p2_count   <= '0;
            p1_present <= 1'b0;
            p2_present <= 1'b0;
            for (int p = 0; p < 2; p++) begin
                x_run[p]   <= '0;
                y_run[p]   <= '0;
                cnt_run[p] <= '0;
            end
        end else begin
            sums_valid <= frame_done;
            if (frame_done) begin
                // hand the frame over to the dividers
                p1_x_sum   <= x_run[0];
                p1_y_sum   <= y_run[0];
                p2_x_sum   <= x_run[1];
                p2_y_sum   <= y_run[1];
                p1_count   <= cnt_run[0];
                p2_count   <= cnt_run[1];
                // an empty count means the led is out of view
                p1_present <= (cnt_run[0] != '0);
                p2_present <= (cnt_run[1] != '0);
                // start the next frame from zero
                for (int p = 0; p < 2; p++) begin
                    x_run[p]   <= '0;
                    y_run[p]   <= '0;
                    cnt_run[p] <= '0;
                end
            end else begin
                // no pixel shares a cycle with frame_done
                for (int p = 0; p < 2; p++) begin
                    if (hit[p]) begin
                        x_run[p]   <= x_run[p] + coord_sum_t'(class_x);
                        y_run[p]   <= y_run[p] + coord_sum_t'(class_y);
                        cnt_run[p] <= cnt_run[p] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- centroid_divider.sv
`include "tracker_params.svh"

module centroid_divider #(
    parameter type quotient_t = pixel_pkg::x_coord_t
) (
    input  logic                     clk_65mhz,
    input  logic                     reset,
    input  logic                     start,
    input  pixel_pkg::coord_sum_t    dividend,
    input  pixel_pkg::pixel_count_t  divisor,
    output logic                     done,
    output quotient_t                quotient
);
    import pixel_pkg::*;

    localparam int step_w = $clog2(`DIV_STEPS + 1);
    localparam int rem_w  = $bits(pixel_count_t);
    localparam int work_w = $bits(coord_sum_t);

    logic [step_w-1:0] steps_left;
    // dividend bits leave at the top, quotient bits enter at the bottom
    coord_sum_t        work;
    pixel_count_t      div_r;
    // partial remainder, always below the divisor
    pixel_count_t      rem;
    logic [rem_w:0]    trial_in;
    logic [rem_w+1:0]  trial;
    logic              fits;

    ////////////////////
    // one restoring step
    ////////////////////

    always_comb begin
        // bring down the next dividend bit
        trial_in = {rem, work[work_w-1]};
        trial    = {1'b0, trial_in} - {2'b00, div_r};
        // no borrow means the divisor goes in once
        fits     = ~trial[rem_w+1];
    end

    // step counter and done pulse
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            steps_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= (steps_left == step_w'(1));
            if (start) begin
                steps_left <= step_w'(`DIV_STEPS);
            end else if (steps_left != '0) begin
                steps_left <= steps_left - 1'b1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk_65mhz) begin
        if (start) begin
            work  <= dividend;
            div_r <= divisor;
            rem   <= '0;
        end else if (steps_left != '0) begin
            // restore by keeping the shifted value when it did not fit
            rem  <= fits ? trial[rem_w-1:0] : trial_in[rem_w-1:0];
            work <= {work[work_w-2:0], fits};
            // last step, low bits of the quotient are the centroid
            if (steps_left == step_w'(1)) begin
                quotient <= quotient_t'({work[work_w-2:0], fits});
            end
        end
    end

endmodule

//--- motion_accumulator.sv
`include "tracker_params.svh"

module motion_accumulator (
    input  logic                 clk_65mhz,
    input  logic                 reset,
    input  logic                 sums_valid,
    input  logic                 p1_present,
    input  logic                 p2_present,
    input  logic                 done,
    input  pixel_pkg::x_coord_t  p1_x,
    input  pixel_pkg::x_coord_t  p2_x,
    input  pixel_pkg::y_coord_t  p1_y,
    input  pixel_pkg::y_coord_t  p2_y,
    output logic                 window_valid,
    output motion_pkg::delta_t   p1_dx,
    output motion_pkg::delta_t   p1_dy,
    output motion_pkg::delta_t   p2_dx,
    output motion_pkg::delta_t   p2_dy
);
    import pixel_pkg::*;
    import motion_pkg::*;

    localparam int tally_w = $clog2(`FRAMES_PER_WINDOW);

    // axes 0..3 are p1 x, p1 y, p2 x, p2 y; rows zero-extended
    x_coord_t           coord_in [4];
    x_coord_t           pos      [4];
    delta_t             step     [4];
    delta_t             running  [4];
    delta_t             total    [4];
    logic [1:0]         present_cur;
    logic [1:0]         present_prev;
    logic [tally_w-1:0] frame_tally;
    logic               last_frame;

    assign coord_in[0] = p1_x;
    assign coord_in[1] = x_coord_t'(p1_y);
    assign coord_in[2] = p2_x;
    assign coord_in[3] = x_coord_t'(p2_y);

    assign last_frame = (frame_tally == tally_w'(`FRAMES_PER_WINDOW - 1));

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // move since last frame, zero unless seen in both frames
            if (present_cur[i/2] && present_prev[i/2]) begin
                step[i] = delta_t'($signed({1'b0, coord_in[i]}) - $signed({1'b0, pos[i]}));
            end else begin
                step[i] = '0;
            end
        end
    end

    // last known position, held while a player is out of view
    always_ff @(posedge clk_65mhz) begin
        if (done) begin
            for (int i = 0; i < 4; i++) begin
                if (present_cur[i/2]) begin
                    pos[i] <= coord_in[i];
                end
            end
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            window_valid <= 1'b0;
            present_cur  <= '0;
            present_prev <= '0;
            frame_tally  <= '0;
            for (int i = 0; i < 4; i++) begin
                running[i] <= '0;
                total[i]   <= '0;
            end
        end else begin
            window_valid <= done && last_frame;
            // flags belong to the frame now in the dividers
            if (sums_valid) begin
                present_cur <= {p2_present, p1_present};
            end
            if (done) begin
                present_prev <= present_cur;
                frame_tally  <= last_frame ? '0 : frame_tally + 1'b1;
                for (int i = 0; i < 4; i++) begin
                    if (last_frame) begin
                        // window closes, this frame's step still counts
                        total[i]   <= running[i] + step[i];
                        running[i] <= '0;
                    end else begin
                        running[i] <= running[i] + step[i];
                    end
                end
            end
        end
    end

    assign p1_dx = total[0];
    assign p1_dy = total[1];
    assign p2_dx = total[2];
    assign p2_dy = total[3];

endmodule

//--- motion_display.sv
module motion_display (
    input  logic                   clk_65mhz,
    input  logic                   reset,
    input  logic                   window_valid,
    input  motion_pkg::delta_t     p1_dx,
    input  motion_pkg::delta_t     p1_dy,
    input  motion_pkg::delta_t     p2_dx,
    input  motion_pkg::delta_t     p2_dy,
    output logic                   motion_valid,
    output motion_pkg::hex_word_t  display_word,
    output logic [3:0]             direction
);
    import motion_pkg::*;

    delta_t     lane_delta [4];
    magnitude_t lane_mag   [4];

    // lane order matches the byte order of the word
    assign lane_delta[lane_p1_dy] = p1_dy;
    assign lane_delta[lane_p1_dx] = p1_dx;
    assign lane_delta[lane_p2_dy] = p2_dy;
    assign lane_delta[lane_p2_dx] = p2_dx;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // negate negatives, the sign goes to the direction bit
            lane_mag[i] = lane_delta[i][8] ? magnitude_t'(-lane_delta[i])
                                           : magnitude_t'(lane_delta[i]);
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            motion_valid <= 1'b0;
            display_word <= '0;
            direction    <= '0;
        end else begin
            motion_valid <= window_valid;
            // display holds the last window until the next one
            if (window_valid) begin
                for (int i = 0; i < 4; i++) begin
                    display_word[8*i +: 8] <= lane_mag[i];
                    // set means right or down
                    direction[i]           <= ~lane_delta[i][8];
                end
            end
        end
    end

endmodule

//--- led_tracker_top.sv
module led_tracker_top (
    input  logic                   clk_65mhz,
    input  logic                   reset,
    input  pixel_pkg::rgb444_t     pixel,
    input  pixel_pkg::x_coord_t    pixel_x,
    input  pixel_pkg::y_coord_t    pixel_y,
    input  logic                   pixel_valid,
    input  logic                   frame_done,
    output logic                   motion_valid,
    output motion_pkg::hex_word_t  display_word,
    output logic [3:0]             direction
);
    import pixel_pkg::*;
    import motion_pkg::*;

    // classifier to accumulator
    logic          class_valid;
    player_class_t pixel_class;
    x_coord_t      class_x;
    y_coord_t      class_y;

    // frame totals to the dividers
    logic         sums_valid;
    coord_sum_t   p1_x_sum;
    coord_sum_t   p1_y_sum;
    coord_sum_t   p2_x_sum;
    coord_sum_t   p2_y_sum;
    pixel_count_t p1_count;
    pixel_count_t p2_count;
    logic         p1_present;
    logic         p2_present;

    // centroids, all four dividers finish together
    logic     div_done;
    x_coord_t p1_x;
    x_coord_t p2_x;
    y_coord_t p1_y;
    y_coord_t p2_y;

    // window totals to the display
    logic   window_valid;
    delta_t p1_dx;
    delta_t p1_dy;
    delta_t p2_dx;
    delta_t p2_dy;

    pixel_classifier pixel_classifier_i (
        .clk_65mhz(clk_65mhz), .reset(reset),
        .pixel(pixel), .pixel_x(pixel_x), .pixel_y(pixel_y), .pixel_valid(pixel_valid),
        .class_valid(class_valid), .pixel_class(pixel_class),
        .class_x(class_x), .class_y(class_y)
    );

    centroid_accumulator centroid_accumulator_i (
        .clk_65mhz(clk_65mhz), .reset(reset),
        .class_valid(class_valid), .pixel_class(pixel_class),
        .class_x(class_x), .class_y(class_y), .frame_done(frame_done),
        .sums_valid(sums_valid),
        .p1_x_sum(p1_x_sum), .p1_y_sum(p1_y_sum),
        .p2_x_sum(p2_x_sum), .p2_y_sum(p2_y_sum),
        .p1_count(p1_count), .p2_count(p2_count),
        .p1_present(p1_present), .p2_present(p2_present)
    );

    ////////////////////
    // centroid dividers
    ////////////////////

    // p1 x drives the shared done
    centroid_divider #(.quotient_t(x_coord_t)) p1_x_div_i (
        .clk_65mhz(clk_65mhz), .reset(reset), .start(sums_valid),
        .dividend(p1_x_sum), .divisor(p1_count), .done(div_done), .quotient(p1_x)
    );
    centroid_divider #(.quotient_t(y_coord_t)) p1_y_div_i (
        .clk_65mhz(clk_65mhz), .reset(reset), .start(sums_valid),
        .dividend(p1_y_sum), .divisor(p1_count), .done(), .quotient(p1_y)
    );
    centroid_divider #(.quotient_t(x_coord_t)) p2_x_div_i (
        .clk_65mhz(clk_65mhz), .reset(reset), .start(sums_valid),
        .dividend(p2_x_sum), .divisor(p2_count), .done(), .quotient(p2_x)
    );
    centroid_divider #(.quotient_t(y_coord_t)) p2_y_div_i (
        .clk_65mhz(clk_65mhz), .reset(reset), .start(sums_valid),
        .dividend(p2_y_sum), .divisor(p2_count), .done(), .quotient(p2_y)
    );

    motion_accumulator motion_accumulator_i (
        .clk_65mhz(clk_65mhz), .reset(reset),
        .sums_valid(sums_valid), .p1_present(p1_present), .p2_present(p2_present),
        .done(div_done), .p1_x(p1_x), .p2_x(p2_x), .p1_y(p1_y), .p2_y(p2_y),
        .window_valid(window_valid),
        .p1_dx(p1_dx), .p1_dy(p1_dy), .p2_dx(p2_dx), .p2_dy(p2_dy)
    );

    motion_display motion_display_i (
        .clk_65mhz(clk_65mhz), .reset(reset), .window_valid(window_valid),
        .p1_dx(p1_dx), .p1_dy(p1_dy), .p2_dx(p2_dx), .p2_dy(p2_dy),
        .motion_valid(motion_valid), .display_word(display_word), .direction(direction)
    );

endmodule

//--- led_tracker_tb.sv
`include "tracker_params.svh"

module led_tracker_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pixel_pkg::*;
    import motion_pkg::*;

    localparam int motion_timeout = 100;
    localparam int motion_latency = 28;

    logic       clk_65mhz;
    logic       reset;
    rgb444_t    pixel;
    x_coord_t   pixel_x;
    y_coord_t   pixel_y;
    logic       pixel_valid;
    logic       frame_done;
    logic       motion_valid;
    hex_word_t  display_word;
    logic [3:0] direction;

    integer seed = 32'h7e6e;

    // reference model state with axes 0..3 as p1 x, p1 y, p2 x and p2 y
    int         sum_x [2];
    int         sum_y [2];
    int         count [2];
    int         pos [4];
    int         running [4];
    bit         was_present [2];
    int         tally;
    bit         window_closed;
    hex_word_t  exp_word;
    logic [3:0] exp_dir;
    // last report seen on the DUT and the expected report of the clean run
    hex_word_t  seen_word;
    logic [3:0] seen_dir;
    hex_word_t  clean_word;
    logic [3:0] clean_dir;

    led_tracker_top led_tracker_top_i (
        .clk_65mhz(clk_65mhz), .reset(reset),
        .pixel(pixel), .pixel_x(pixel_x), .pixel_y(pixel_y),
        .pixel_valid(pixel_valid), .frame_done(frame_done),
        .motion_valid(motion_valid), .display_word(display_word), .direction(direction)
    );

    initial begin
        clk_65mhz = 1'b0;
        forever #20 clk_65mhz = ~clk_65mhz;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // returns 0 for none, 1 for the red led and 2 for the white led
    function automatic int classify(input logic [11:0] rgb);
        int r;
        int g;
        int b;
        r = rgb[11:8];
        g = rgb[7:4];
        b = rgb[3:0];
        if (r > `P1_RED_MIN && g < `P1_OTHER_MAX && b < `P1_OTHER_MAX) begin
            return 1;
        end else if (r > `P2_MIN && g > `P2_MIN && b > `P2_MIN) begin
            return 2;
        end
        return 0;
    endfunction

    task automatic reset_model();
        for (int p = 0; p < 2; p++) begin
            sum_x[p]       = 0;
            sum_y[p]       = 0;
            count[p]       = 0;
            was_present[p] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            pos[i]     = 0;
            running[i] = 0;
        end
        tally    = 0;
        exp_word = '0;
        exp_dir  = '0;
    endtask

    // centroids, steps and window totals for the frame just ended
    task automatic close_frame_model();
        int cur [4];
        bit here [2];
        int step;
        int lane;
        int mag;
        for (int p = 0; p < 2; p++) begin
            here[p] = (count[p] != 0);
            // floor division is only meaningful with pixels present
            cur[2*p]   = here[p] ? sum_x[p] / count[p] : 0;
            cur[2*p+1] = here[p] ? sum_y[p] / count[p] : 0;
        end
        tally++;
        window_closed = (tally == `FRAMES_PER_WINDOW);
        for (int i = 0; i < 4; i++) begin
            // a step needs the player in this frame and the one before
            step = (here[i/2] && was_present[i/2]) ? cur[i] - pos[i] : 0;
            if (here[i/2]) begin
                pos[i] = cur[i];
            end
            running[i] += step;
            if (window_closed) begin
                // bytes from the bottom hold p1 dy, p1 dx, p2 dy and p2 dx
                lane = i ^ 1;
                mag  = (running[i] < 0) ? -running[i] : running[i];
                exp_word[8*lane +: 8] = mag[7:0];
                exp_dir[lane]         = (running[i] >= 0);
                running[i]            = 0;
            end
        end
        if (window_closed) begin
            tally = 0;
        end
        for (int p = 0; p < 2; p++) begin
            was_present[p] = here[p];
            sum_x[p]       = 0;
            sum_y[p]       = 0;
            count[p]       = 0;
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic send_pixel(input logic [11:0] rgb, input int x, input int y, input bit valid);
        int who;
        @(posedge clk_65mhz);
        pixel       <= rgb;
        pixel_x     <= x_coord_t'(x);
        pixel_y     <= y_coord_t'(y);
        pixel_valid <= valid;
        // only valid in-area pixels reach the sums
        who = classify(rgb);
        if (valid && x < `FRAME_WIDTH && y < `FRAME_HEIGHT && who != 0) begin
            sum_x[who-1] += x;
            sum_y[who-1] += y;
            count[who-1] += 1;
        end
    endtask

    task automatic add_noise(input int n);
        int x;
        int y;
        for (int i = 0; i < n; i++) begin
            x = {$random(seed)} % `FRAME_WIDTH;
            y = {$random(seed)} % `FRAME_HEIGHT;
            case (i % 6)
                // red below 8 fails both colour tests
                0, 1: send_pixel(12'($random(seed)) & 12'h7ff, x, y, 1'b1);
                // one channel right on a threshold
                2: send_pixel(((i / 6) % 2) ? 12'hccc : 12'hf30, x, y, 1'b1);
                // bright pixels in the blanking area
                3: send_pixel(12'hf00, 320 + {$random(seed)} % 192, y, 1'b1);
                4: send_pixel(12'hfff, x, 240 + {$random(seed)} % 16, 1'b1);
                // bright but not valid
                default: send_pixel(12'hf00, x, y, 1'b0);
            endcase
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_65mhz);
        reset       <= 1'b1;
        pixel_valid <= 1'b0;
        frame_done  <= 1'b0;
        repeat (8) @(posedge clk_65mhz);
        reset <= 1'b0;
        reset_model();
        @(negedge clk_65mhz);
        check_value("motion_valid", motion_valid, 0);
        check_value("display_word", display_word, 0);
        check_value("direction", direction, 0);
    endtask

    task automatic run_frame(input bit p1_on, input int p1x, input int p1y,
                             input bit p2_on, input int p2x, input int p2y, input bit noisy);
        int cycles;
        if (noisy) begin
            add_noise(12);
        end
        // 3x3 red spot around the target
        if (p1_on) begin
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    send_pixel((dx == 0) ? 12'hf10 : 12'he21, p1x + dx, p1y + dy, 1'b1);
                end
            end
        end
        if (noisy) begin
            add_noise(12);
        end
        // 4x2 white spot whose floor centroid lands on the target
        if (p2_on) begin
            for (int dy = 0; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 2; dx++) begin
                    send_pixel((dy == 0) ? 12'hfff : 12'hdde, p2x + dx, p2y + dy, 1'b1);
                end
            end
        end
        @(posedge clk_65mhz);
        pixel_valid <= 1'b0;
        @(posedge clk_65mhz);
        @(posedge clk_65mhz);
        frame_done <= 1'b1;
        @(posedge clk_65mhz);
        frame_done <= 1'b0;
        close_frame_model();
        if (window_closed) begin
            // count edges since frame_done was driven
            cycles = 1;
            @(negedge clk_65mhz);
            while (!motion_valid) begin
                if (cycles >= motion_timeout) begin
                    $display("motion_valid never came after the last frame of the window");
                    $display("Testbench failed");
                    $fatal(1);
                end
                @(posedge clk_65mhz);
                cycles++;
                @(negedge clk_65mhz);
            end
            check_value("motion_valid latency", cycles, motion_latency);
            check_value("display_word", display_word, exp_word);
            check_value("direction", direction, exp_dir);
            seen_word = display_word;
            seen_dir  = direction;
            repeat (4) @(posedge clk_65mhz);
        end else begin
            // mid-window the display holds the previous report
            repeat (30) begin
                @(negedge clk_65mhz);
                check_value("motion_valid", motion_valid, 0);
                check_value("display_word", display_word, exp_word);
                check_value("direction", direction, exp_dir);
            end
        end
    endtask

    initial begin
        reset       <= 1'b1;
        pixel       <= '0;
        pixel_x     <= '0;
        pixel_y     <= '0;
        pixel_valid <= 1'b0;
        frame_done  <= 1'b0;
        seen_word   = '0;
        seen_dir    = '0;

        // stationary spots give zero motion and every direction bit set
        apply_reset();
        for (int f = 0; f < 16; f++) begin
            run_frame(1'b1, 100, 50, 1'b1, 200, 120, 1'b0);
        end
        check_value("display_word", seen_word, 32'h0);
        check_value("direction", seen_dir, 4'hf);

        // two windows with p1 moving right and up and p2 moving left and down
        apply_reset();
        for (int f = 0; f < 32; f++) begin
            run_frame(1'b1, 40 + 2*f, 150 - f, 1'b1, 250 - 3*f, 30 + 2*f, 1'b0);
            if (f == 15) begin
                // 15 steps give p2 45 left and 30 down with p1 30 right and 15 up
                check_value("display_word", seen_word, 32'h2d1e1e0f);
                check_value("direction", seen_dir, 4'h6);
                clean_word = exp_word;
                clean_dir  = exp_dir;
            end
        end
        // the second window adds a 16th step
        check_value("display_word", seen_word, 32'h30202010);
        check_value("direction", seen_dir, 4'h6);

        // same motion buried in background and blanking noise
        apply_reset();
        for (int f = 0; f < 16; f++) begin
            run_frame(1'b1, 40 + 2*f, 150 - f, 1'b1, 250 - 3*f, 30 + 2*f, 1'b1);
        end
        check_value("display_word against clean run", seen_word, clean_word);
        check_value("direction against clean run", seen_dir, clean_dir);

        // p1 drops out for 5 frames and then returns somewhere else
        apply_reset();
        for (int f = 0; f < 16; f++) begin
            run_frame(f < 5 || f >= 10, (f < 10) ? 60 + f : 120 + f, 60,
                      1'b1, 180, 100 + f, 1'b1);
        end
        // p1 gains 4 columns before the gap and 5 after it while p2 gains 15 rows
        check_value("display_word", seen_word, 32'h000f0900);
        check_value("direction", seen_dir, 4'hf);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
pixel_pkg.sv
motion_pkg.sv
pixel_classifier.sv
centroid_accumulator.sv
centroid_divider.sv
motion_accumulator.sv
motion_display.sv
led_tracker_top.sv
led_tracker_tb.sv
